// ==== Bender.yml ====
package:
  name: tlp_tx_cntrl

sources:
  - include_dirs:
      - common
    files:
      - common/tlp_tx_pkg.sv
      - common/rd_seg_if.sv
      - rd_path/rd_req_splitter.sv
      - rd_path/pending_rd_tracker.sv
      - src/msi_request.sv
      - src/cmd_arbiter.sv
      - src/tlp_tx_cntrl.sv

  - target: test
    include_dirs:
      - common
      - tb
    files:
      - tb/tb_tlp_tx_cntrl.sv

// ==== common/rd_seg_if.sv ====
`timescale 1ns/1ps

// read segments from the splitter to the command arbiter
interface rd_seg_if;

  logic        seg_valid;   // fields below stable while high
  logic [63:0] seg_addr;
  logic [8:0]  seg_len_dw;
  logic [3:0]  seg_fbe;
  logic [3:0]  seg_lbe;
  logic        seg_last;    // last segment of the avalon read
  logic        rd_idle;     // splitter may accept a new read

  logic        seg_take;    // one cycle, header written
  logic        rd_allow;    // master enabled and no msi pending

  modport producer (
    output seg_valid, seg_addr, seg_len_dw, seg_fbe, seg_lbe, seg_last, rd_idle,
    input  seg_take, rd_allow
  );

  modport consumer (
    input  seg_valid, seg_addr, seg_len_dw, seg_fbe, seg_lbe, seg_last, rd_idle,
    output seg_take, rd_allow
  );

endinterface

// ==== common/tlp_tx_pkg.sv ====
`include "tlp_tx_settings.svh"

package tlp_tx_pkg;

  typedef logic [`BURST_W-1:0] burst_t;

  // byte counts up to one full 4 KB page
  typedef logic [12:0] rd_bytes_t;

  typedef logic [3:0] tag_t;

  // mailbox register select, address bits 2:0
  typedef logic [2:0] mbox_idx_t;

  // avalon byte enable of one 16-byte word
  typedef union packed {
    logic [15:0]     word;   // whole pattern
    logic [3:0][3:0] nib;    // one nibble per dword
  } avl_be_u;

  // command fifo entry, 91 bits
  typedef struct packed {
    logic        last_sub_read;   // final segment of an avalon read
    logic [3:0]  lbe;
    logic [8:0]  len_dw;
    logic        is_msi;
    tag_t        tag;
    logic [3:0]  fbe;
    logic        is_wr64;
    logic        is_wr32;
    logic        is_rd64;
    logic        is_rd32;
    logic [63:0] addr;
  } tlp_hdr_t;

endpackage

// ==== common/tlp_tx_settings.svh ====
`ifndef TLP_TX_SETTINGS_SVH
`define TLP_TX_SETTINGS_SVH

// avalon slave side
`define AVL_ADDR_WIDTH 32       // byte address
`define BURST_W 6               // burst count width

// outstanding read bookkeeping
`define MAX_OUTSTANDING_RD 8
`define PND_FIFO_DEPTH 16       // burst counts held by the tracker

// command fifo fill level up to which a header is still written
`define CMD_FIFO_OK_LEVEL 8

// interrupt sources
`define IRQ_NUM 1
`define MBOX_IRQ_BASE 16        // pcie_irq_ena bit of mailbox 0

// reads may not cross this address boundary
`define BOUNDARY_BYTES 4096

`endif

// ==== project.f ====
+incdir+common
+incdir+tb
common/tlp_tx_pkg.sv
common/rd_seg_if.sv
rd_path/rd_req_splitter.sv
rd_path/pending_rd_tracker.sv
src/msi_request.sv
src/cmd_arbiter.sv
src/tlp_tx_cntrl.sv
tb/tb_tlp_tx_cntrl.sv

// ==== rd_path/pending_rd_tracker.sv ====
`timescale 1ns/1ps
`include "tlp_tx_settings.svh"

module pending_rd_tracker
  import tlp_tx_pkg::*;
(
  input  logic   AvlClk_i,
  input  logic   Rstn_i,
  input  logic   rd_accept_i,
  input  burst_t rd_burst_i,
  input  logic   txs_read_data_valid_i,
  output logic   rd_limit_o
);

  localparam int PTR_W = $clog2(`PND_FIFO_DEPTH);
  localparam int OUT_W = $clog2(`MAX_OUTSTANDING_RD + 1);

  burst_t           fifo_mem [`PND_FIFO_DEPTH];
  logic [PTR_W:0]   wr_ptr_q;
  logic [PTR_W:0]   rd_ptr_q;
  logic             fifo_empty;
  logic             pop;

  logic             head_vld_q;
  burst_t           head_cnt_q;   // burst count of the oldest read
  burst_t           data_cnt_q;   // data strobes returned for it
  logic             done;

  logic [OUT_W-1:0] outstanding_q;
  logic             rd_limit_q;

  assign fifo_empty = (wr_ptr_q == rd_ptr_q);
  assign done       = head_vld_q && (data_cnt_q == head_cnt_q);
  assign pop        = !fifo_empty && (!head_vld_q || done);

  always_ff @(posedge AvlClk_i)
  begin
    if (rd_accept_i)
      fifo_mem[wr_ptr_q[PTR_W-1:0]] <= rd_burst_i;
    if (pop)
      head_cnt_q <= fifo_mem[rd_ptr_q[PTR_W-1:0]];
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      head_vld_q    <= 1'b0;
      data_cnt_q    <= '0;
      outstanding_q <= '0;
      rd_limit_q    <= 1'b0;
    end
    else
    begin
      if (rd_accept_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;

      if (pop)
        head_vld_q <= 1'b1;
      else if (done)
        head_vld_q <= 1'b0;

      // a strobe in the done cycle already belongs to the next read
      if (done)
        data_cnt_q <= txs_read_data_valid_i ? burst_t'(1) : burst_t'(0);
      else if (txs_read_data_valid_i)
        data_cnt_q <= data_cnt_q + 1'b1;

      case ({rd_accept_i, done})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase

      rd_limit_q <= (outstanding_q >= OUT_W'(`MAX_OUTSTANDING_RD));
    end
  end

  assign rd_limit_o = rd_limit_q;

endmodule

// ==== rd_path/rd_req_splitter.sv ====
`timescale 1ns/1ps
`include "tlp_tx_settings.svh"

module rd_req_splitter
  import tlp_tx_pkg::*;
(
  input  logic                       AvlClk_i,
  input  logic                       Rstn_i,
  input  logic                       tx_chip_select_i,
  input  logic                       tx_read_i,
  input  burst_t                     tx_burst_count_i,
  input  logic [`AVL_ADDR_WIDTH-1:0] tx_address_i,
  input  avl_be_u                    tx_byte_enable_i,
  input  logic [31:0]                dev_csr_i,
  input  logic                       rd_limit_i,
  output logic                       tx_wait_request_o,
  output logic                       rd_accept_o,
  output burst_t                     rd_burst_o,
  rd_seg_if.producer                 seg
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_CALC = 2'd1;   // pipeline cycle, segment size registered
  localparam logic [1:0] ST_SEG  = 2'd2;   // segment offered to the arbiter

  localparam int BND_BITS = $clog2(`BOUNDARY_BYTES);

  logic [1:0]                 state_q;
  logic [`AVL_ADDR_WIDTH-1:0] addr_q;
  rd_bytes_t                  remain_q;
  rd_bytes_t                  seg_bytes_q;
  logic                       seg_last_q;

  logic                       accept;
  logic                       partial;
  logic [2:0]                 num_dw;
  logic [1:0]                 first_dw;
  logic [`AVL_ADDR_WIDTH-1:0] req_addr;
  rd_bytes_t                  req_bytes;
  rd_bytes_t                  max_rd;
  rd_bytes_t                  to_bnd;
  rd_bytes_t                  seg_bytes;

  // max read request size from device control
  always_comb
  begin
    case (dev_csr_i[14:12])
      3'b000:  max_rd = 13'd128;
      3'b001:  max_rd = 13'd256;
      default: max_rd = 13'd512;
    endcase
  end

  // dword count from the whole pattern, start dword from the nibbles
  always_comb
  begin
    case (tx_byte_enable_i.word)
      16'h000F, 16'h00F0, 16'h0F00, 16'hF000: num_dw = 3'd1;
      16'h00FF, 16'h0FF0, 16'hFF00:           num_dw = 3'd2;
      16'h0FFF, 16'hFFF0:                     num_dw = 3'd3;
      default:                                num_dw = 3'd4;
    endcase
    first_dw = 2'd0;
    for (int i = 3; i >= 0; i--)
    begin
      if (tx_byte_enable_i.nib[i] != 4'h0)
        first_dw = i[1:0];   // lowest enabled dword wins
    end
  end

  assign partial = (tx_burst_count_i == burst_t'(1)) && (tx_byte_enable_i.word != 16'hFFFF);

  assign req_addr  = partial ? {tx_address_i[`AVL_ADDR_WIDTH-1:4], first_dw, 2'b00}
                             : {tx_address_i[`AVL_ADDR_WIDTH-1:4], 4'h0};
  assign req_bytes = partial ? rd_bytes_t'({num_dw, 2'b00})
                             : rd_bytes_t'({tx_burst_count_i, 4'h0});

  assign accept = tx_chip_select_i & tx_read_i & (state_q == ST_IDLE) & seg.rd_allow &
                  ~rd_limit_i;

  assign tx_wait_request_o = ~accept;
  assign rd_accept_o       = accept;
  assign rd_burst_o        = tx_burst_count_i;

  // smallest of remaining bytes, max read size and distance to the boundary
  assign to_bnd = rd_bytes_t'(`BOUNDARY_BYTES) - rd_bytes_t'(addr_q[BND_BITS-1:0]);

  always_comb
  begin
    seg_bytes = remain_q;
    if (max_rd < seg_bytes)
      seg_bytes = max_rd;
    if (to_bnd < seg_bytes)
      seg_bytes = to_bnd;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state_q <= ST_IDLE;
    else
    begin
      case (state_q)
        ST_IDLE: if (accept) state_q <= ST_CALC;
        ST_CALC: state_q <= ST_SEG;
        ST_SEG:
          if (seg.seg_take)
            state_q <= seg_last_q ? ST_IDLE : ST_CALC;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // address and byte bookkeeping
  always_ff @(posedge AvlClk_i)
  begin
    if (accept)
    begin
      addr_q   <= req_addr;
      remain_q <= req_bytes;
    end
    else if ((state_q == ST_SEG) && seg.seg_take)
    begin
      addr_q   <= addr_q + `AVL_ADDR_WIDTH'(seg_bytes_q);
      remain_q <= remain_q - seg_bytes_q;
    end

    if (state_q == ST_CALC)
    begin
      seg_bytes_q <= seg_bytes;
      seg_last_q  <= (seg_bytes == remain_q);
    end
  end

  assign seg.seg_valid  = (state_q == ST_SEG);
  assign seg.seg_addr   = {{(64-`AVL_ADDR_WIDTH){1'b0}}, addr_q};   // translation bypassed
  assign seg.seg_len_dw = seg_bytes_q[10:2];
  assign seg.seg_fbe    = 4'hF;
  assign seg.seg_lbe    = (seg_bytes_q == 13'd4) ? 4'h0 : 4'hF;   // single dword has no lbe
  assign seg.seg_last   = seg_last_q;
  assign seg.rd_idle    = (state_q == ST_IDLE);

endmodule

// ==== src/cmd_arbiter.sv ====
`timescale 1ns/1ps
`include "tlp_tx_settings.svh"

module cmd_arbiter
  import tlp_tx_pkg::*;
(
  input  logic        AvlClk_i,
  input  logic        Rstn_i,
  input  logic [3:0]  cmd_fifo_usedw_i,
  input  logic        master_enable_i,
  input  logic [63:0] msi_addr_i,
  input  logic        msi_pending_i,
  rd_seg_if.consumer  seg,
  output logic        msi_sent_o,
  output logic        tx_req_wr_o,
  output tlp_hdr_t    tx_req_header_o,
  output logic        cmd_fifo_busy_o
);

  logic     cmd_ok;
  logic     msi_sel;   // msi owns the header mux
  logic     msi_go;
  logic     rd_go;
  tag_t     tag_q;
  tlp_hdr_t hdr;

  assign cmd_ok  = (cmd_fifo_usedw_i <= 4'(`CMD_FIFO_OK_LEVEL));
  assign msi_sel = msi_pending_i & seg.rd_idle;
  assign msi_go  = msi_sel & cmd_ok & master_enable_i;
  assign rd_go   = seg.seg_valid & cmd_ok;   // never together with msi_go, splitter busy

  assign seg.seg_take = rd_go;
  assign seg.rd_allow = master_enable_i & ~msi_pending_i;

  always_comb
  begin
    hdr     = '0;
    hdr.tag = tag_q;
    if (msi_sel)
    begin
      hdr.len_dw  = 9'd1;
      hdr.fbe     = 4'hF;
      hdr.is_msi  = 1'b1;
      hdr.is_wr64 = |msi_addr_i[63:32];
      hdr.is_wr32 = ~|msi_addr_i[63:32];
      hdr.addr    = msi_addr_i;
    end
    else
    begin
      hdr.last_sub_read = seg.seg_last;
      hdr.lbe           = seg.seg_lbe;
      hdr.len_dw        = seg.seg_len_dw;
      hdr.fbe           = seg.seg_fbe;
      hdr.is_rd64       = |seg.seg_addr[63:32];
      hdr.is_rd32       = ~|seg.seg_addr[63:32];
      hdr.addr          = seg.seg_addr;
    end
  end

  // tags advance on reads only
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      tag_q <= '0;
    else if (rd_go)
      tag_q <= tag_q + 1'b1;
  end

  assign tx_req_wr_o     = msi_go | rd_go;
  assign tx_req_header_o = hdr;
  assign msi_sent_o      = msi_go;
  assign cmd_fifo_busy_o = msi_pending_i | seg.seg_valid;   // a header is waiting

endmodule

// ==== src/msi_request.sv ====
`timescale 1ns/1ps
`include "tlp_tx_settings.svh"

module msi_request
  import tlp_tx_pkg::*;
(
  input  logic                AvlClk_i,
  input  logic                Rstn_i,
  input  logic [`IRQ_NUM-1:0] rxm_irq_i,
  input  logic [31:0]         pcie_irq_ena_i,
  input  logic [15:0]         msi_csr_i,
  input  logic [11:0]         a2p_mb_wr_addr_i,
  input  logic                a2p_mb_wr_req_i,
  input  logic                msi_sent_i,
  output logic                msi_pending_o
);

  logic      irq_act;
  logic      irq_q;
  logic      irq_rise;
  mbox_idx_t mbox_idx;
  logic      mbox_hit;
  logic      msi_set;
  logic      pending_q;

  // enabled interrupt lines folded into one level
  assign irq_act  = |(rxm_irq_i & pcie_irq_ena_i[`IRQ_NUM-1:0]);
  assign irq_rise = irq_act & ~irq_q;

  assign mbox_idx = a2p_mb_wr_addr_i[2:0];
  assign mbox_hit = a2p_mb_wr_req_i & pcie_irq_ena_i[`MBOX_IRQ_BASE + mbox_idx];

  assign msi_set = (irq_rise | mbox_hit) & msi_csr_i[0];   // msi enable

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      irq_q     <= 1'b0;
      pending_q <= 1'b0;
    end
    else
    begin
      irq_q <= irq_act;
      if (msi_set)
        pending_q <= 1'b1;   // further triggers merge into this one
      else if (msi_sent_i)
        pending_q <= 1'b0;
    end
  end

  assign msi_pending_o = pending_q;

endmodule

// ==== src/tlp_tx_cntrl.sv ====
`timescale 1ns/1ps
`include "tlp_tx_settings.svh"

module tlp_tx_cntrl
  import tlp_tx_pkg::*;
(
  input  logic                       AvlClk_i,
  input  logic                       Rstn_i,
  input  logic                       tx_chip_select_i,
  input  logic                       tx_read_i,
  input  logic [`BURST_W-1:0]        tx_burst_count_i,
  input  logic [`AVL_ADDR_WIDTH-1:0] tx_address_i,
  input  logic [15:0]                tx_byte_enable_i,
  input  logic [3:0]                 cmd_fifo_usedw_i,
  input  logic [31:0]                dev_csr_i,
  input  logic                       master_enable_i,
  input  logic [15:0]                msi_csr_i,
  input  logic [63:0]                msi_addr_i,
  input  logic [31:0]                pcie_irq_ena_i,
  input  logic [11:0]                a2p_mb_wr_addr_i,
  input  logic                       a2p_mb_wr_req_i,
  input  logic                       txs_read_data_valid_i,
  input  logic [`IRQ_NUM-1:0]        rxm_irq_i,
  output logic                       tx_wait_request_o,
  output logic                       tx_req_wr_o,
  output tlp_hdr_t                   tx_req_header_o,
  output logic                       cmd_fifo_busy_o
);

  logic   rd_accept;
  burst_t rd_burst;
  logic   rd_limit;
  logic   msi_pending;
  logic   msi_sent;

  rd_seg_if rd_seg ();

  rd_req_splitter rd_req_splitter_i (
    .AvlClk_i          (AvlClk_i),
    .Rstn_i            (Rstn_i),
    .tx_chip_select_i  (tx_chip_select_i),
    .tx_read_i         (tx_read_i),
    .tx_burst_count_i  (tx_burst_count_i),
    .tx_address_i      (tx_address_i),
    .tx_byte_enable_i  (tx_byte_enable_i),
    .dev_csr_i         (dev_csr_i),
    .rd_limit_i        (rd_limit),
    .tx_wait_request_o (tx_wait_request_o),
    .rd_accept_o       (rd_accept),
    .rd_burst_o        (rd_burst),
    .seg               (rd_seg.producer)
  );

  pending_rd_tracker pending_rd_tracker_i (
    .AvlClk_i              (AvlClk_i),
    .Rstn_i                (Rstn_i),
    .rd_accept_i           (rd_accept),
    .rd_burst_i            (rd_burst),
    .txs_read_data_valid_i (txs_read_data_valid_i),
    .rd_limit_o            (rd_limit)
  );

  msi_request msi_request_i (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .rxm_irq_i        (rxm_irq_i),
    .pcie_irq_ena_i   (pcie_irq_ena_i),
    .msi_csr_i        (msi_csr_i),
    .a2p_mb_wr_addr_i (a2p_mb_wr_addr_i),
    .a2p_mb_wr_req_i  (a2p_mb_wr_req_i),
    .msi_sent_i       (msi_sent),
    .msi_pending_o    (msi_pending)
  );

  cmd_arbiter cmd_arbiter_i (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .cmd_fifo_usedw_i (cmd_fifo_usedw_i),
    .master_enable_i  (master_enable_i),
    .msi_addr_i       (msi_addr_i),
    .msi_pending_i    (msi_pending),
    .seg              (rd_seg.consumer),
    .msi_sent_o       (msi_sent),
    .tx_req_wr_o      (tx_req_wr_o),
    .tx_req_header_o  (tx_req_header_o),
    .cmd_fifo_busy_o  (cmd_fifo_busy_o)
  );

endmodule

// ==== tb/tlp_tx_ref.svh ====
`ifndef TLP_TX_REF_SVH
`define TLP_TX_REF_SVH

// xorshift32, one step
function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// expected headers of one avalon read, appended to exp_q
function automatic void ref_read(input logic [31:0] addr, input int burst,
                                 input logic [15:0] be, input logic [2:0] mrs);
  int          i;
  int          lo;
  int          hi;
  int          left;
  int          lim;
  int          seg;
  int          room;
  logic [31:0] a;
  tlp_hdr_t    h;
  lim  = (mrs == 3'd0) ? 128 : (mrs == 3'd1) ? 256 : 512;
  a    = {addr[31:4], 4'h0};
  left = burst * 16;
  if (burst == 1 && be != 16'hFFFF)
  begin
    lo = 4;
    hi = -1;
    for (i = 0; i < 4; i++)
    begin
      if (be[i*4 +: 4] != 4'h0 && lo == 4)
        lo = i;   // first enabled dword
      if (be[i*4 +: 4] != 4'h0)
        hi = i;
    end
    a    = a + 32'(lo * 4);
    left = (hi - lo + 1) * 4;
  end
  req_bytes_q.push_back(left);
  while (left > 0)
  begin
    seg  = (left < lim) ? left : lim;
    room = `BOUNDARY_BYTES - int'(a % `BOUNDARY_BYTES);   // bytes up to the next page
    if (room < seg)
      seg = room;
    h               = '0;
    h.addr          = {32'h0, a};
    h.len_dw        = 9'(seg / 4);
    h.fbe           = 4'hF;
    h.lbe           = (seg == 4) ? 4'h0 : 4'hF;
    h.tag           = exp_tag;
    h.is_rd32       = 1'b1;
    h.last_sub_read = (seg == left);
    exp_q.push_back(h);
    exp_tag = exp_tag + 1'b1;
    a       = a + 32'(seg);
    left    = left - seg;
  end
endfunction

// expected msi write header, tag not consumed
function automatic void ref_msi(input logic [63:0] addr);
  tlp_hdr_t h;
  h         = '0;
  h.addr    = addr;
  h.len_dw  = 9'd1;
  h.fbe     = 4'hF;
  h.is_msi  = 1'b1;
  h.tag     = exp_tag;
  h.is_wr64 = (addr[63:32] != 32'h0);
  h.is_wr32 = (addr[63:32] == 32'h0);
  exp_q.push_back(h);
endfunction

`endif

// ==== tb/tb_tlp_tx_cntrl.sv ====
`timescale 1ns/1ps
`include "tlp_tx_settings.svh"

module tb_tlp_tx_cntrl
  import tlp_tx_pkg::*;
();

  localparam int N_READS   = 45;
  localparam int WD_CYCLES = 10 + N_READS * 100 + 600;
  localparam logic [15:0] BE_LIST [9] = '{16'h000F, 16'h00F0, 16'h0F00, 16'hF000,
                                          16'h00FF, 16'hFF00,
                                          16'h0FF0, 16'h0FFF, 16'hFFF0};

  logic                       AvlClk_i;
  logic                       Rstn_i;
  logic                       tx_chip_select_i;
  logic                       tx_read_i;
  logic [`BURST_W-1:0]        tx_burst_count_i;
  logic [`AVL_ADDR_WIDTH-1:0] tx_address_i;
  logic [15:0]                tx_byte_enable_i;
  logic [3:0]                 cmd_fifo_usedw_i;
  logic [31:0]                dev_csr_i;
  logic                       master_enable_i;
  logic [15:0]                msi_csr_i;
  logic [63:0]                msi_addr_i;
  logic [31:0]                pcie_irq_ena_i;
  logic [11:0]                a2p_mb_wr_addr_i;
  logic                       a2p_mb_wr_req_i;
  logic                       txs_read_data_valid_i;
  logic [`IRQ_NUM-1:0]        rxm_irq_i;
  logic                       tx_wait_request_o;
  logic                       tx_req_wr_o;
  tlp_hdr_t                   tx_req_header_o;
  logic                       cmd_fifo_busy_o;

  tlp_hdr_t    exp_q [$];     // headers still to come, in order
  int          req_bytes_q [$];
  int          pend_q [$];    // burst counts waiting for read data
  tag_t        exp_tag;
  tlp_hdr_t    got_hdr;
  tlp_hdr_t    exp_hdr;
  logic [31:0] rnd;
  logic [31:0] rd_base;
  logic [31:0] rd_addr;
  logic [63:0] nxt_addr;
  logic        in_read;
  int          sum_bytes;
  int          errors;
  int          check_count;
  int          err_mark;
  int          beat_cnt;
  int          data_credit;
  int          n_wait;
  bit          auto_data;

  `include "tlp_tx_ref.svh"

  tlp_tx_cntrl tlp_tx_cntrl_i (.*);

  always #50 AvlClk_i = ~AvlClk_i;

  task automatic tick();
    @(posedge AvlClk_i);
    #10;
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic start_read(input logic [31:0] addr, input int burst, input logic [15:0] be);
    tick();
    tx_chip_select_i = 1'b1;
    tx_read_i        = 1'b1;
    tx_address_i     = addr;
    tx_burst_count_i = burst;
    tx_byte_enable_i = be;
  endtask

  // wait-request is combinational, so it is looked at mid cycle
  task automatic accept_read(input int limit);
    int n;
    n = 0;
    @(negedge AvlClk_i);
    while (tx_wait_request_o && n < limit)
    begin
      @(negedge AvlClk_i);
      n++;
    end
    if (tx_wait_request_o)
    begin
      $display("read at %h was not accepted within %0d cycles", tx_address_i, limit);
      errors++;
    end
    else
    begin
      ref_read(tx_address_i, tx_burst_count_i, tx_byte_enable_i, dev_csr_i[14:12]);
      pend_q.push_back(tx_burst_count_i);
    end
    tick();
    tx_chip_select_i = 1'b0;
    tx_read_i        = 1'b0;
  endtask

  task automatic do_read(input logic [31:0] addr, input int burst, input logic [15:0] be);
    start_read(addr, burst, be);
    accept_read(400);
  endtask

  task automatic wait_headers(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit)
    begin
      @(negedge AvlClk_i);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      $display("%0d expected headers missing after %0d cycles", exp_q.size(), limit);
      errors++;
      exp_q.delete();
      req_bytes_q.delete();
      in_read   = 1'b0;
      sum_bytes = 0;
    end
    repeat (4) @(negedge AvlClk_i);
  endtask

  task automatic print_test_result(input string name);
    if (errors == err_mark)
      $display("%s: ok", name);
    else
      $display("%s: FAILED with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // read data return, one strobe per cycle for the oldest read
  initial
  begin
    forever
    begin
      tick();
      txs_read_data_valid_i = 1'b0;
      if (pend_q.size() != 0 && (auto_data || data_credit > 0))
      begin
        txs_read_data_valid_i = 1'b1;
        if (!auto_data)
          data_credit--;
        beat_cnt++;
        if (beat_cnt == pend_q[0])
        begin
          void'(pend_q.pop_front());
          beat_cnt = 0;
        end
      end
    end
  end

  // header checker
  always @(negedge AvlClk_i)
  begin
    if (Rstn_i && tx_req_wr_o)
    begin
      got_hdr = tx_req_header_o;
      if (exp_q.size() == 0)
      begin
        $display("header to %h was written while none was expected", got_hdr.addr);
        errors++;
      end
      else
      begin
        exp_hdr = exp_q.pop_front();
        check_value("addr", got_hdr.addr, exp_hdr.addr);
        check_value("len_dw", got_hdr.len_dw, exp_hdr.len_dw);
        check_value("fbe", got_hdr.fbe, exp_hdr.fbe);
        check_value("lbe", got_hdr.lbe, exp_hdr.lbe);
        check_value("tag", got_hdr.tag, exp_hdr.tag);
        check_value("last_sub_read", got_hdr.last_sub_read, exp_hdr.last_sub_read);
        check_value("type flags",
                    {got_hdr.is_msi, got_hdr.is_wr64, got_hdr.is_wr32, got_hdr.is_rd64,
                     got_hdr.is_rd32},
                    {exp_hdr.is_msi, exp_hdr.is_wr64, exp_hdr.is_wr32, exp_hdr.is_rd64,
                     exp_hdr.is_rd32});
        if (!got_hdr.is_msi)
        begin
          if (in_read)
            check_value("addr contiguity", got_hdr.addr, nxt_addr);
          nxt_addr  = got_hdr.addr + 64'(got_hdr.len_dw) * 4;
          sum_bytes = sum_bytes + got_hdr.len_dw * 4;
          in_read   = !got_hdr.last_sub_read;
          if (got_hdr.last_sub_read)
          begin
            check_value("read byte total", sum_bytes, req_bytes_q.pop_front());
            sum_bytes = 0;
          end
        end
      end
    end
  end

  initial
  begin
    #(WD_CYCLES * 100);
    $display("watchdog expired after %0d cycles before the tests completed", WD_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  initial
  begin
    AvlClk_i              = 1'b0;
    Rstn_i                = 1'b0;
    tx_chip_select_i      = 1'b0;
    tx_read_i             = 1'b0;
    tx_burst_count_i      = '0;
    tx_address_i          = '0;
    tx_byte_enable_i      = 16'hFFFF;
    cmd_fifo_usedw_i      = 4'd0;
    dev_csr_i             = 32'h0;   // 128 byte reads
    master_enable_i       = 1'b1;
    msi_csr_i             = 16'h0;
    msi_addr_i            = 64'h0;
    pcie_irq_ena_i        = 32'h0;
    a2p_mb_wr_addr_i      = 12'h0;
    a2p_mb_wr_req_i       = 1'b0;
    txs_read_data_valid_i = 1'b0;
    rxm_irq_i             = '0;
    rnd                   = 32'h1d8a_f354;
    exp_tag               = '0;
    in_read               = 1'b0;
    sum_bytes             = 0;
    errors                = 0;
    check_count           = 0;
    err_mark              = 0;
    beat_cnt              = 0;
    data_credit           = 0;
    auto_data             = 1'b1;

    repeat (10) @(posedge AvlClk_i);
    #10;
    Rstn_i = 1'b1;
    @(negedge AvlClk_i);
    check_value("tx_wait_request_o", tx_wait_request_o, 1'b1);
    check_value("tx_req_wr_o", tx_req_wr_o, 1'b0);
    check_value("cmd_fifo_busy_o", cmd_fifo_busy_o, 1'b0);

    // 1: one header per read, second read ends right at the page end
    do_read(32'h0002_0100, 4, 16'hFFFF);
    do_read(32'h0003_0F80, 8, 16'hFFFF);
    wait_headers(200);
    print_test_result("test 1 single header reads");

    // 2: random reads close to a page end, for each max read size code
    for (int m = 0; m < 4; m++)
    begin
      tick();
      dev_csr_i = 32'(m) << 12;
      for (int k = 0; k < 6; k++)
      begin
        rnd     = xorshift(rnd);
        rd_base = {4'h0, rnd[27:12], 12'h000};
        rnd     = xorshift(rnd);
        rd_addr = rd_base + 32'h1000 - 32'((rnd[4:0] + 1) * 16);
        rnd     = xorshift(rnd);
        do_read(rd_addr, 1 + rnd % 48, 16'hFFFF);
      end
      wait_headers(800);
    end
    print_test_result("test 2 split reads");

    // 3: single beats with partial dword enables
    for (int k = 0; k < 9; k++)
    begin
      rnd = xorshift(rnd);
      do_read({4'h0, rnd[27:4], 4'h0}, 1, BE_LIST[k]);
    end
    wait_headers(200);
    print_test_result("test 3 partial enables");

    // 4: outstanding read limit
    n_wait = 0;
    while (pend_q.size() != 0 && n_wait < 2000)
    begin
      @(negedge AvlClk_i);
      n_wait++;
    end
    repeat (4) @(negedge AvlClk_i);
    auto_data = 1'b0;
    for (int k = 0; k < `MAX_OUTSTANDING_RD; k++)
      do_read(32'h0010_0000 + 32'(k * 256), 2, 16'hFFFF);
    start_read(32'h0010_0800, 2, 16'hFFFF);
    repeat (20)
    begin
      @(negedge AvlClk_i);
      check_value("tx_wait_request_o", tx_wait_request_o, 1'b1);
    end
    data_credit = pend_q[0];   // data of the first read only
    accept_read(60);
    auto_data = 1'b1;
    wait_headers(200);
    print_test_result("test 4 outstanding limit");

    // 5: msi from an interrupt rise and from a mailbox write
    tick();
    msi_csr_i      = 16'h0001;
    pcie_irq_ena_i = 32'h0008_0001;   // irq 0 and mailbox 3
    msi_addr_i     = 64'h0000_0000_FEE0_1000;
    rxm_irq_i      = 1'b1;
    ref_msi(msi_addr_i);
    wait_headers(100);
    tick();
    rxm_irq_i        = 1'b0;
    msi_addr_i       = 64'h0000_0001_FEE0_2000;
    a2p_mb_wr_addr_i = 12'h003;
    a2p_mb_wr_req_i  = 1'b1;
    ref_msi(msi_addr_i);
    tick();
    a2p_mb_wr_req_i = 1'b0;
    wait_headers(100);
    tick();
    msi_csr_i       = 16'h0;
    rxm_irq_i       = 1'b1;
    a2p_mb_wr_req_i = 1'b1;
    tick();
    a2p_mb_wr_req_i = 1'b0;
    rxm_irq_i       = 1'b0;
    tick();
    msi_csr_i      = 16'h0001;
    pcie_irq_ena_i = 32'h0;
    tick();
    rxm_irq_i       = 1'b1;
    a2p_mb_wr_req_i = 1'b1;
    tick();
    a2p_mb_wr_req_i = 1'b0;
    repeat (10)
    begin
      @(negedge AvlClk_i);
      check_value("cmd_fifo_busy_o", cmd_fifo_busy_o, 1'b0);
    end
    tick();
    rxm_irq_i = 1'b0;
    print_test_result("test 5 msi requests");

    // 6: command fifo back-pressure
    tick();
    dev_csr_i        = 32'h0;
    cmd_fifo_usedw_i = 4'd9;
    do_read(32'h0040_0F40, 40, 16'hFFFF);
    for (int i = 0; i < 12; i++)
    begin
      @(negedge AvlClk_i);
      check_value("tx_req_wr_o", tx_req_wr_o, 1'b0);
      if (i >= 2)
        check_value("cmd_fifo_busy_o", cmd_fifo_busy_o, 1'b1);
    end
    tick();
    cmd_fifo_usedw_i = 4'(`CMD_FIFO_OK_LEVEL);
    wait_headers(200);
    print_test_result("test 6 fifo back-pressure");

    $display("checks %0d, errors %0d", check_count, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule
